// ==== Bender.yml ====
package:
  name: gpu_top

sources:
  - rtl/gpu_pkg.sv
  - rtl/fb_draw_engine.sv
  - rtl/frame_buffer.sv
  - rtl/vga_timing.sv
  - rtl/pixel_scanout.sv
  - rtl/gpu_top.sv
  - target: test
    files:
      - dv/gpu_top_tb.sv

// ==== dv/gpu_patterns.txt ====
# C op x y len color_hex wait_idle | F = check next full frame
# E x y color_hex = pixel expected in the last checked frame
C 3 0 0 0 001f 1
F
E 5 3 001f
C 1 2 1 0 f800 1
C 2 4 2 5 07e0 1
C 2 12 5 9 ffff 1
C 0 0 0 0 0000 1
F
E 2 1 f800
E 4 2 07e0
E 8 2 07e0
E 9 2 001f
E 12 5 ffff
E 15 5 ffff
E 11 5 001f
C 3 0 0 0 a5a5 0
C 1 7 7 0 1234 1
F
E 7 7 a5a5
E 0 0 a5a5
C 2 0 7 16 7bef 1
F
E 15 7 7bef
E 3 6 a5a5

// ==== dv/gpu_top_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module gpu_top_tb;

  localparam int H_ACTIVE   = 16;
  localparam int H_FRONT    = 2;
  localparam int H_SYNC     = 3;
  localparam int H_BACK     = 3;
  localparam int V_ACTIVE   = 8;
  localparam int V_FRONT    = 1;
  localparam int V_SYNC     = 2;
  localparam int V_BACK     = 1;
  localparam int PIX_DIV    = 4;
  localparam int H_TOTAL    = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL    = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int DEPTH      = H_ACTIVE * V_ACTIVE;
  localparam int FRAME_CYC  = H_TOTAL * V_TOTAL * PIX_DIV;
  localparam int BUSY_LIMIT = 2 * DEPTH + 16;
  localparam int X_W        = $clog2(H_ACTIVE);
  localparam int Y_W        = $clog2(V_ACTIVE);
  localparam int LEN_W      = $clog2(H_ACTIVE + 1);

  logic                        Clk;
  logic                        arst_n;
  logic                        cmd_strobe;
  gpu_pkg::draw_op_e           cmd_op;
  logic [X_W-1:0]              cmd_x;
  logic [Y_W-1:0]              cmd_y;
  logic [LEN_W-1:0]            cmd_len;
  logic [gpu_pkg::PIX_W-1:0]   cmd_color;
  logic                        busy;
  logic [gpu_pkg::RED_W-1:0]   red;
  logic [gpu_pkg::GREEN_W-1:0] green;
  logic [gpu_pkg::BLUE_W-1:0]  blue;
  logic                        hsync;
  logic                        vsync;
  logic                        vde;
  logic [X_W-1:0]              draw_x;
  logic [Y_W-1:0]              draw_y;

  // Expected framebuffer and the last scanned frame
  logic [gpu_pkg::PIX_W-1:0] model [DEPTH];
  logic [gpu_pkg::PIX_W-1:0] seen [DEPTH];
  // Edge counter and first edge at which a strobe is taken again
  int cyc;
  int free_at;
  int errors;

  gpu_top #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
    .PIX_DIV(PIX_DIV)
  ) gpu_top_i (.*);

  always #2 Clk = ~Clk;

  always @(posedge Clk) begin
    cyc <= cyc + 1;
  end

  task automatic wait_idle();
    int n;
    logic idle;
    idle = 1'b0;
    for (n = 0; n < BUSY_LIMIT && !idle; n++) begin
      @(posedge Clk);
      idle = !busy;
    end
    if (!idle) begin
      errors++;
      $display("timeout: busy stayed high for %0d cycles", BUSY_LIMIT);
    end
  endtask

  task automatic send_cmd(input int op, input int x, input int y, input int len,
                          input logic [gpu_pkg::PIX_W-1:0] color, input int wait_done);
    int s;
    int n;
    int i;
    @(posedge Clk);
    cmd_strobe <= 1'b1;
    cmd_op     <= gpu_pkg::draw_op_e'(op);
    cmd_x      <= X_W'(x);
    cmd_y      <= Y_W'(y);
    cmd_len    <= LEN_W'(len);
    cmd_color  <= color;
    @(posedge Clk);
    s = cyc;
    cmd_strobe <= 1'b0;
    // Strobe sampled at edge s, ignored while the engine runs
    if (s >= free_at) begin
      case (gpu_pkg::draw_op_e'(op))
        gpu_pkg::OP_PIXEL: model[y * H_ACTIVE + x] = color;
        gpu_pkg::OP_HLINE: begin
          n = H_ACTIVE - x;
          if (len < n) begin
            n = len;
          end
          for (i = 0; i < n; i++) begin
            model[y * H_ACTIVE + x + i] = color;
          end
          if (n > 0) begin
            free_at = s + n + 1;
          end
        end
        gpu_pkg::OP_CLEAR: begin
          for (i = 0; i < DEPTH; i++) begin
            model[i] = color;
          end
          free_at = s + DEPTH + 1;
        end
        default: begin
        end
      endcase
    end
    @(negedge Clk);
    assert (busy === (s + 1 < free_at)) else begin
      errors++;
      $display("error at %0t: busy is %b after op %0d, expected %b",
               $time, busy, op, s + 1 < free_at);
    end
    if (wait_done != 0) begin
      wait_idle();
    end
  endtask

  task automatic check_frame();
    int n;
    int addr;
    int cycles;
    int vde_cyc;
    int vs_low;
    int hs_falls;
    logic found;
    logic prev_hs;
    logic prev_vs;
    logic [gpu_pkg::PIX_W-1:0] pix;
    found    = 1'b0;
    cycles   = 0;
    vde_cyc  = 0;
    vs_low   = 0;
    hs_falls = 0;
    @(negedge Clk);
    prev_hs = hsync;
    prev_vs = vsync;
    // A frame runs from one vsync fall to the next
    for (n = 0; n < 2 * FRAME_CYC && !found; n++) begin
      @(negedge Clk);
      found   = prev_vs && !vsync;
      prev_hs = hsync;
      prev_vs = vsync;
    end
    if (!found) begin
      errors++;
      $display("timeout: no vsync pulse seen while waiting for a frame");
    end else begin
      found = 1'b0;
      for (n = 0; n < 2 * FRAME_CYC && !found; n++) begin
        pix = {red, green, blue};
        if (vde) begin
          // Active pixels arrive in raster order, PIX_DIV cycles each
          addr = vde_cyc / PIX_DIV;
          vde_cyc++;
          assert (int'(draw_x) == addr % H_ACTIVE && int'(draw_y) == addr / H_ACTIVE) else begin
            errors++;
            $display("error at %0t: position (%0d,%0d), expected (%0d,%0d)",
                     $time, draw_x, draw_y, addr % H_ACTIVE, addr / H_ACTIVE);
          end
          if (addr < DEPTH) begin
            seen[addr] = pix;
          end
          assert (pix === model[addr]) else begin
            errors++;
            $display("error at %0t: pixel (%0d,%0d) is %h, expected %h",
                     $time, addr % H_ACTIVE, addr / H_ACTIVE, pix, model[addr]);
          end
        end else begin
          assert (pix === '0) else begin
            errors++;
            $display("error at %0t: colour %h while vde is low", $time, pix);
          end
        end
        if (!vsync) begin
          vs_low++;
        end
        cycles++;
        @(negedge Clk);
        if (prev_hs && !hsync) begin
          hs_falls++;
        end
        found   = prev_vs && !vsync;
        prev_hs = hsync;
        prev_vs = vsync;
      end
      if (!found) begin
        errors++;
        $display("timeout: frame did not end with a second vsync pulse");
      end else begin
        assert (cycles == FRAME_CYC && vde_cyc == DEPTH * PIX_DIV &&
                hs_falls == V_TOTAL && vs_low == V_SYNC * H_TOTAL * PIX_DIV) else begin
          errors++;
          $display("error at %0t: frame %0d cyc, vde %0d, hsync %0d, vsync low %0d",
                   $time, cycles, vde_cyc, hs_falls, vs_low);
        end
      end
    end
  endtask

  task automatic check_pixel(input int x, input int y, input logic [gpu_pkg::PIX_W-1:0] color);
    assert (seen[y * H_ACTIVE + x] === color) else begin
      errors++;
      $display("error at %0t: scanned pixel (%0d,%0d) is %h, pattern expects %h",
               $time, x, y, seen[y * H_ACTIVE + x], color);
    end
  endtask

  initial begin
    int fd;
    int code;
    int op;
    int x;
    int y;
    int len;
    int wt;
    logic more;
    logic [7:0] kind;
    logic [8*128-1:0] line;
    logic [gpu_pkg::PIX_W-1:0] color;
    Clk        = 1'b0;
    arst_n     = 1'b0;
    cmd_strobe = 1'b0;
    cmd_op     = gpu_pkg::OP_NOP;
    cmd_x      = '0;
    cmd_y      = '0;
    cmd_len    = '0;
    cmd_color  = '0;
    cyc        = 0;
    free_at    = 0;
    errors     = 0;
    repeat (16) @(posedge Clk);
    arst_n <= 1'b1;
    @(negedge Clk);
    assert (!busy && hsync && vsync && !vde) else begin
      errors++;
      $display("error at %0t: after reset busy %b hsync %b vsync %b vde %b",
               $time, busy, hsync, vsync, vde);
    end
    fd = $fopen("dv/gpu_patterns.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the patterns file dv/gpu_patterns.txt");
    end else begin
      more = 1'b1;
      while (more) begin
        code = $fscanf(fd, " %c", kind);
        if (code != 1) begin
          more = 1'b0;
        end else if (kind == "#") begin
          code = $fgets(line, fd);
        end else if (kind == "C") begin
          code = $fscanf(fd, "%d %d %d %d %h %d", op, x, y, len, color, wt);
          send_cmd(op, x, y, len, color, wt);
        end else if (kind == "F") begin
          check_frame();
        end else if (kind == "E") begin
          code = $fscanf(fd, "%d %d %h", x, y, color);
          check_pixel(x, y, color);
        end else begin
          errors++;
          $display("patterns file holds an unknown record kind '%c'", kind);
          more = 1'b0;
        end
      end
      $fclose(fd);
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== gpu_top.f ====
rtl/gpu_pkg.sv
rtl/fb_draw_engine.sv
rtl/frame_buffer.sv
rtl/vga_timing.sv
rtl/pixel_scanout.sv
rtl/gpu_top.sv
dv/gpu_top_tb.sv

// ==== rtl/fb_draw_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module fb_draw_engine #(
  parameter int H_ACTIVE = 16,
  parameter int V_ACTIVE = 8
) (
  input  logic                                 Clk,
  input  logic                                 arst_n,
  input  logic                                 cmd_strobe,
  input  gpu_pkg::draw_op_e                    cmd_op,
  input  logic [$clog2(H_ACTIVE)-1:0]          cmd_x,
  input  logic [$clog2(V_ACTIVE)-1:0]          cmd_y,
  input  logic [$clog2(H_ACTIVE+1)-1:0]        cmd_len,
  input  logic [gpu_pkg::PIX_W-1:0]            cmd_color,
  output logic                                 busy,
  output logic                                 wr_en,
  output logic [$clog2(H_ACTIVE*V_ACTIVE)-1:0] wr_addr,
  output logic [gpu_pkg::PIX_W-1:0]            wr_data
);

  localparam int LEN_W  = $clog2(H_ACTIVE + 1);
  localparam int DEPTH  = H_ACTIVE * V_ACTIVE;
  localparam int ADDR_W = $clog2(DEPTH);

  gpu_pkg::draw_state_e      state;
  gpu_pkg::draw_op_e         op_q;
  logic [LEN_W-1:0]          remain_q;
  logic [gpu_pkg::PIX_W-1:0] color_q;

  logic                      accept;
  logic                      coord_ok;
  logic [LEN_W-1:0]          row_room;
  logic [LEN_W-1:0]          line_cnt;
  logic [ADDR_W-1:0]         start_addr;
  logic                      last_write;

  // Commands only land while idle
  assign accept     = cmd_strobe && (state == gpu_pkg::ST_IDLE);
  assign coord_ok   = (cmd_x < H_ACTIVE) && (cmd_y < V_ACTIVE);

  // Pixels left in the row from cmd_x onwards
  assign row_room   = LEN_W'(H_ACTIVE) - LEN_W'(cmd_x);
  assign line_cnt   = (cmd_len > row_room) ? row_room : cmd_len;
  assign start_addr = ADDR_W'(cmd_y) * ADDR_W'(H_ACTIVE) + ADDR_W'(cmd_x);

  // Clear ends on the last word, a line when its count runs out
  assign last_write = (op_q == gpu_pkg::OP_CLEAR) ? (wr_addr == ADDR_W'(DEPTH - 1))
                                                  : (remain_q == '0);

  assign busy    = (state == gpu_pkg::ST_RUN);
  assign wr_data = color_q;

  always_ff @(posedge Clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= gpu_pkg::ST_IDLE;
      op_q     <= gpu_pkg::OP_NOP;
      wr_en    <= 1'b0;
      wr_addr  <= '0;
      remain_q <= '0;
    end else begin
      case (state)
        gpu_pkg::ST_IDLE: begin
          wr_en <= 1'b0;
          if (accept) begin
            op_q <= cmd_op;
            case (cmd_op)
              gpu_pkg::OP_PIXEL: begin
                // One write, engine stays idle
                wr_en   <= coord_ok;
                wr_addr <= start_addr;
              end
              gpu_pkg::OP_HLINE: begin
                if (coord_ok && (line_cnt != '0)) begin
                  wr_en    <= 1'b1;
                  wr_addr  <= start_addr;
                  remain_q <= line_cnt - 1'b1;
                  state    <= gpu_pkg::ST_RUN;
                end
              end
              gpu_pkg::OP_CLEAR: begin
                wr_en   <= 1'b1;
                wr_addr <= '0;
                state   <= gpu_pkg::ST_RUN;
              end
              default: begin
              end
            endcase
          end
        end
        gpu_pkg::ST_RUN: begin
          if (last_write) begin
            wr_en <= 1'b0;
            state <= gpu_pkg::ST_IDLE;
          end else begin
            wr_addr  <= wr_addr + 1'b1;
            remain_q <= remain_q - 1'b1;
          end
        end
        default: state <= gpu_pkg::ST_IDLE;
      endcase
    end
  end

  // Colour held for the whole command
  always_ff @(posedge Clk) begin
    if (accept) begin
      color_q <= cmd_color;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/frame_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module frame_buffer #(
  parameter int DEPTH = 128
) (
  input  logic                      Clk,
  input  logic                      wr_en,
  input  logic [$clog2(DEPTH)-1:0]  wr_addr,
  input  logic [gpu_pkg::PIX_W-1:0] wr_data,
  input  logic [$clog2(DEPTH)-1:0]  rd_addr,
  output logic [gpu_pkg::PIX_W-1:0] rd_data
);

  // One RGB565 word per pixel, row-major
  logic [gpu_pkg::PIX_W-1:0] mem [DEPTH];

  // Write port from the draw engine
  always_ff @(posedge Clk) begin
    if (wr_en && (wr_addr < DEPTH)) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read port for scanout
  // Same-address collision returns the old word
  always_ff @(posedge Clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// ==== rtl/gpu_pkg.sv ====
`default_nettype none

package gpu_pkg;

  // RGB565 field layout, red in the top bits
  localparam int RED_W   = 5;
  localparam int GREEN_W = 6;
  localparam int BLUE_W  = 5;

  // Full framebuffer word
  localparam int PIX_W   = RED_W + GREEN_W + BLUE_W;

  // Host drawing commands
  typedef enum logic [1:0] {
    // No operation
    OP_NOP   = 2'd0,
    // Single pixel at x, y
    OP_PIXEL = 2'd1,
    // Horizontal run of len pixels, cut at the row end
    OP_HLINE = 2'd2,
    // Whole framebuffer in one colour
    OP_CLEAR = 2'd3
  } draw_op_e;

  // Draw engine sequencing
  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_RUN  = 1'b1
  } draw_state_e;

endpackage

`default_nettype wire

// ==== rtl/gpu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module gpu_top #(
  parameter int H_ACTIVE = 16,
  parameter int H_FRONT  = 2,
  parameter int H_SYNC   = 3,
  parameter int H_BACK   = 3,
  parameter int V_ACTIVE = 8,
  parameter int V_FRONT  = 1,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 1,
  parameter int PIX_DIV  = 4
) (
  input  logic                          Clk,
  input  logic                          arst_n,
  input  logic                          cmd_strobe,
  input  gpu_pkg::draw_op_e             cmd_op,
  input  logic [$clog2(H_ACTIVE)-1:0]   cmd_x,
  input  logic [$clog2(V_ACTIVE)-1:0]   cmd_y,
  input  logic [$clog2(H_ACTIVE+1)-1:0] cmd_len,
  input  logic [gpu_pkg::PIX_W-1:0]     cmd_color,
  output logic                          busy,
  output logic [gpu_pkg::RED_W-1:0]     red,
  output logic [gpu_pkg::GREEN_W-1:0]   green,
  output logic [gpu_pkg::BLUE_W-1:0]    blue,
  output logic                          hsync,
  output logic                          vsync,
  output logic                          vde,
  output logic [$clog2(H_ACTIVE)-1:0]   draw_x,
  output logic [$clog2(V_ACTIVE)-1:0]   draw_y
);

  localparam int DEPTH  = H_ACTIVE * V_ACTIVE;
  localparam int ADDR_W = $clog2(DEPTH);
  localparam int X_W    = $clog2(H_ACTIVE);
  localparam int Y_W    = $clog2(V_ACTIVE);

  // Draw side
  logic                      wr_en;
  logic [ADDR_W-1:0]         wr_addr;
  logic [gpu_pkg::PIX_W-1:0] wr_data;

  // Scanout side
  logic [ADDR_W-1:0]         rd_addr;
  logic [gpu_pkg::PIX_W-1:0] rd_data;
  logic [X_W-1:0]            pos_x;
  logic [Y_W-1:0]            pos_y;
  logic                      raster_hsync;
  logic                      raster_vsync;
  logic                      raster_active;

  fb_draw_engine #(
    .H_ACTIVE(H_ACTIVE),
    .V_ACTIVE(V_ACTIVE)
  ) draw_engine_i (
    .Clk       (Clk),
    .arst_n    (arst_n),
    .cmd_strobe(cmd_strobe),
    .cmd_op    (cmd_op),
    .cmd_x     (cmd_x),
    .cmd_y     (cmd_y),
    .cmd_len   (cmd_len),
    .cmd_color (cmd_color),
    .busy      (busy),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data)
  );

  frame_buffer #(
    .DEPTH(DEPTH)
  ) frame_buffer_i (
    .Clk    (Clk),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .rd_addr(rd_addr),
    .rd_data(rd_data)
  );

  // Pixel strobe is internal to the raster timing
  vga_timing #(
    .H_ACTIVE(H_ACTIVE),
    .H_FRONT (H_FRONT),
    .H_SYNC  (H_SYNC),
    .H_BACK  (H_BACK),
    .V_ACTIVE(V_ACTIVE),
    .V_FRONT (V_FRONT),
    .V_SYNC  (V_SYNC),
    .V_BACK  (V_BACK),
    .PIX_DIV (PIX_DIV)
  ) vga_timing_i (
    .Clk   (Clk),
    .arst_n(arst_n),
    .pix_en(),
    .pos_x (pos_x),
    .pos_y (pos_y),
    .hsync (raster_hsync),
    .vsync (raster_vsync),
    .active(raster_active)
  );

  pixel_scanout #(
    .H_ACTIVE(H_ACTIVE),
    .V_ACTIVE(V_ACTIVE)
  ) pixel_scanout_i (
    .Clk     (Clk),
    .arst_n  (arst_n),
    .pos_x   (pos_x),
    .pos_y   (pos_y),
    .hsync_in(raster_hsync),
    .vsync_in(raster_vsync),
    .active  (raster_active),
    .rd_data (rd_data),
    .rd_addr (rd_addr),
    .red     (red),
    .green   (green),
    .blue    (blue),
    .hsync   (hsync),
    .vsync   (vsync),
    .vde     (vde),
    .draw_x  (draw_x),
    .draw_y  (draw_y)
  );

endmodule

`default_nettype wire

// ==== rtl/pixel_scanout.sv ====
`timescale 1ns/100ps
`default_nettype none

module pixel_scanout #(
  parameter int H_ACTIVE = 16,
  parameter int V_ACTIVE = 8
) (
  input  logic                                 Clk,
  input  logic                                 arst_n,
  input  logic [$clog2(H_ACTIVE)-1:0]          pos_x,
  input  logic [$clog2(V_ACTIVE)-1:0]          pos_y,
  input  logic                                 hsync_in,
  input  logic                                 vsync_in,
  input  logic                                 active,
  input  logic [gpu_pkg::PIX_W-1:0]            rd_data,
  output logic [$clog2(H_ACTIVE*V_ACTIVE)-1:0] rd_addr,
  output logic [gpu_pkg::RED_W-1:0]            red,
  output logic [gpu_pkg::GREEN_W-1:0]          green,
  output logic [gpu_pkg::BLUE_W-1:0]           blue,
  output logic                                 hsync,
  output logic                                 vsync,
  output logic                                 vde,
  output logic [$clog2(H_ACTIVE)-1:0]          draw_x,
  output logic [$clog2(V_ACTIVE)-1:0]          draw_y
);

  localparam int ADDR_W = $clog2(H_ACTIVE * V_ACTIVE);

  // Row-major fetch of the current raster pixel
  assign rd_addr = ADDR_W'(pos_y) * ADDR_W'(H_ACTIVE) + ADDR_W'(pos_x);

  // Delay sync and position to meet the memory read latency
  always_ff @(posedge Clk or negedge arst_n) begin
    if (!arst_n) begin
      hsync  <= 1'b1;
      vsync  <= 1'b1;
      vde    <= 1'b0;
      draw_x <= '0;
      draw_y <= '0;
    end else begin
      hsync  <= hsync_in;
      vsync  <= vsync_in;
      vde    <= active;
      draw_x <= pos_x;
      draw_y <= pos_y;
    end
  end

  // RGB565 split, black during blanking
  assign red   = vde ? rd_data[gpu_pkg::PIX_W-1 -: gpu_pkg::RED_W] : '0;
  assign green = vde ? rd_data[gpu_pkg::BLUE_W +: gpu_pkg::GREEN_W] : '0;
  assign blue  = vde ? rd_data[0 +: gpu_pkg::BLUE_W] : '0;

endmodule

`default_nettype wire

// ==== rtl/vga_timing.sv ====
`timescale 1ns/100ps
`default_nettype none

module vga_timing #(
  parameter int H_ACTIVE = 16,
  parameter int H_FRONT  = 2,
  parameter int H_SYNC   = 3,
  parameter int H_BACK   = 3,
  parameter int V_ACTIVE = 8,
  parameter int V_FRONT  = 1,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 1,
  parameter int PIX_DIV  = 4
) (
  input  logic                        Clk,
  input  logic                        arst_n,
  output logic                        pix_en,
  output logic [$clog2(H_ACTIVE)-1:0] pos_x,
  output logic [$clog2(V_ACTIVE)-1:0] pos_y,
  output logic                        hsync,
  output logic                        vsync,
  output logic                        active
);

  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int HS_START = H_ACTIVE + H_FRONT;
  localparam int HS_END   = HS_START + H_SYNC;
  localparam int VS_START = V_ACTIVE + V_FRONT;
  localparam int VS_END   = VS_START + V_SYNC;
  localparam int X_W      = $clog2(H_ACTIVE);
  localparam int Y_W      = $clog2(V_ACTIVE);
  localparam int HC_W     = $clog2(H_TOTAL);
  localparam int VC_W     = $clog2(V_TOTAL);
  localparam int DIV_W    = (PIX_DIV > 1) ? $clog2(PIX_DIV) : 1;

  logic [DIV_W-1:0] div_q;
  logic [HC_W-1:0]  h_cnt;
  logic [VC_W-1:0]  v_cnt;
  logic             h_last;
  logic             v_last;
  logic             h_vis;
  logic             v_vis;

  assign pix_en = (div_q == DIV_W'(PIX_DIV - 1));
  assign h_last = (h_cnt == HC_W'(H_TOTAL - 1));
  assign v_last = (v_cnt == VC_W'(V_TOTAL - 1));
  assign h_vis  = (h_cnt < H_ACTIVE);
  assign v_vis  = (v_cnt < V_ACTIVE);

  // Pixel rate divider
  always_ff @(posedge Clk or negedge arst_n) begin
    if (!arst_n) begin
      div_q <= '0;
    end else if (pix_en) begin
      div_q <= '0;
    end else begin
      div_q <= div_q + 1'b1;
    end
  end

  // Line and frame counters
  always_ff @(posedge Clk or negedge arst_n) begin
    if (!arst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (pix_en) begin
      if (h_last) begin
        h_cnt <= '0;
        v_cnt <= v_last ? '0 : v_cnt + 1'b1;
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  // Raster outputs, one decode per pixel strobe
  always_ff @(posedge Clk or negedge arst_n) begin
    if (!arst_n) begin
      pos_x  <= '0;
      pos_y  <= '0;
      hsync  <= 1'b1;
      vsync  <= 1'b1;
      active <= 1'b0;
    end else if (pix_en) begin
      pos_x  <= h_vis ? h_cnt[X_W-1:0] : '0;
      pos_y  <= v_vis ? v_cnt[Y_W-1:0] : '0;
      hsync  <= !((h_cnt >= HS_START) && (h_cnt < HS_END));
      vsync  <= !((v_cnt >= VS_START) && (v_cnt < VS_END));
      active <= h_vis && v_vis;
    end
  end

endmodule

`default_nettype wire
